//--- aesKey_consts.svh
`ifndef AES_KEY_CONSTS_SVH
`define AES_KEY_CONSTS_SVH

// Expansion rounds for a 128-bit key
`define AES_NUM_ROUNDS 10

// Cipher key width in bytes
`define AES_KEY_BYTES 16

// One schedule word
`define AES_WORD_BYTES 4

// Original key plus one key per round
`define AES_SCHED_KEYS 11

`endif

//--- AESDefinitions.sv
`include "aesKey_consts.svh"

package AESDefinitions;

    // **********************************************************
    // Basic key types
    // **********************************************************

    typedef logic [7:0] byte_t;

    // Byte 0 sits in the most significant position
    typedef byte_t [0:`AES_WORD_BYTES-1] dword_t;
    typedef byte_t [0:`AES_KEY_BYTES-1] roundKey_t;

    // Entry 0 is the cipher key itself
    typedef roundKey_t [0:`AES_SCHED_KEYS-1] schedule_t;

    // Pipeline stage payload
    typedef struct packed {
        logic      valid;
        schedule_t sched;
    } keyStage_t;

    // Round key store occupancy
    typedef enum logic {
        storeEmpty,
        storeLoaded
    } storeState_t;

    // **********************************************************
    // Substitution box
    // **********************************************************

    // FIPS-197 forward S-box, row major by high nibble
    localparam byte_t SBOX_TABLE [0:255] = '{
        8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
        8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
        8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
        8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
        8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
        8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
        8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
        8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
        8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
        8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
        8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
        8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
        8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
        8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
        8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
        8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
        8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
        8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
        8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
        8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
        8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
        8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
        8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
        8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
        8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
        8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
        8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
        8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
        8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
        8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
        8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
        8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
    };

    // Plain table lookup, maps to LUTs or ROM
    function automatic byte_t sbox(input byte_t in);
        return SBOX_TABLE[in];
    endfunction

endpackage

//--- KeyRound.sv
`timescale 1ns/1ps
`include "aesKey_consts.svh"

module KeyRound #(
    parameter int RCON_ITER = 1
) (
    input  AESDefinitions::roundKey_t prevKey,
    output AESDefinitions::roundKey_t roundKey
);

    import AESDefinitions::*;

    localparam int WORD_BYTES = `AES_WORD_BYTES;
    localparam int KEY_WORDS  = `AES_KEY_BYTES / `AES_WORD_BYTES;

    // Round constant first byte per round number
    localparam byte_t RCON_TABLE [1:10] = '{
        8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
        8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

    // **********************************************************
    // Word helpers
    // **********************************************************

    // One byte left with byte 0 wrapping to the end
    function automatic dword_t rot4(input dword_t in);
        return {in[1], in[2], in[3], in[0]};
    endfunction

    // S-box on every byte of the word
    function automatic dword_t sub4(input dword_t in);
        dword_t out;
        for (int i = 0; i < WORD_BYTES; i++)
        begin
            out[i] = sbox(in[i]);
        end
        return out;
    endfunction

    function automatic byte_t rcon(input int iter);
        return RCON_TABLE[iter];
    endfunction

    // RotWord, SubWord, then round constant into the first byte
    function automatic dword_t scheduleCore(input dword_t in, input int iter);
        dword_t out;
        out = sub4(rot4(in));
        out[0] ^= rcon(iter);
        return out;
    endfunction

    // **********************************************************
    // Round key derivation
    // **********************************************************

    always_comb
    begin
        dword_t word;
        // First word mixes the core output of the last previous word
        word = scheduleCore(prevKey[(KEY_WORDS-1)*WORD_BYTES +: WORD_BYTES], RCON_ITER);
        word ^= prevKey[0 +: WORD_BYTES];
        roundKey[0 +: WORD_BYTES] = word;
        // Remaining words chain through the new key
        for (int w = 1; w < KEY_WORDS; w++)
        begin
            word ^= prevKey[w*WORD_BYTES +: WORD_BYTES];
            roundKey[w*WORD_BYTES +: WORD_BYTES] = word;
        end
    end

endmodule

//--- KeyExpansion.sv
`timescale 1ns/1ps
`include "aesKey_consts.svh"

module KeyExpansion (
    input  logic                      clk,
    input  logic                      arstN,
    input  AESDefinitions::roundKey_t keyIn,
    input  logic                      keyValid,
    output AESDefinitions::schedule_t schedOut,
    output logic                      schedValid
);

    import AESDefinitions::*;

    localparam int NUM_ROUNDS = `AES_NUM_ROUNDS;

    // Stage r holds entries 0..r of its key's schedule
    keyStage_t stageQ [0:NUM_ROUNDS];

    // Round key from each expander, before its register
    roundKey_t roundKeyW [1:NUM_ROUNDS];

    // **********************************************************
    // Stage 0, key capture
    // **********************************************************

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            stageQ[0].valid <= 1'b0;
        end
        else
        begin
            stageQ[0].valid <= keyValid;
            // Data only moves with a key, saves toggling when idle
            if (keyValid)
            begin
                stageQ[0].sched[0] <= keyIn;
            end
        end
    end

    // **********************************************************
    // Rounds 1 to 10
    // **********************************************************

    for (genvar r = 1; r <= NUM_ROUNDS; r++)
    begin : g_round
        schedule_t schedNext;

        // Previous stage's newest entry feeds this round
        KeyRound #(
            .RCON_ITER (r)
        ) i_keyRound (
            .prevKey  (stageQ[r-1].sched[r-1]),
            .roundKey (roundKeyW[r])
        );

        // Carry earlier entries, append this round's key
        always_comb
        begin
            schedNext    = stageQ[r-1].sched;
            schedNext[r] = roundKeyW[r];
        end

        always_ff @(posedge clk or negedge arstN)
        begin
            if (!arstN)
            begin
                stageQ[r].valid <= 1'b0;
            end
            else
            begin
                stageQ[r].valid <= stageQ[r-1].valid;
                if (stageQ[r-1].valid)
                begin
                    stageQ[r].sched <= schedNext;
                end
            end
        end
    end

    // Last stage carries the full schedule
    assign schedOut   = stageQ[NUM_ROUNDS].sched;
    assign schedValid = stageQ[NUM_ROUNDS].valid;

endmodule

//--- RoundKeyStore.sv
`timescale 1ns/1ps
`include "aesKey_consts.svh"

module RoundKeyStore (
    input  logic                      clk,
    input  logic                      arstN,
    input  AESDefinitions::schedule_t schedIn,
    input  logic                      schedValid,
    input  logic [3:0]                rdRound,
    output AESDefinitions::roundKey_t rdKey,
    output logic                      keyReady
);

    import AESDefinitions::*;

    // Highest valid read index
    localparam logic [3:0] LAST_ROUND = 4'(`AES_SCHED_KEYS - 1);

    storeState_t stateQ;
    storeState_t stateD;
    schedule_t   schedQ;

    // **********************************************************
    // Occupancy FSM
    // **********************************************************

    always_comb
    begin
        stateD = stateQ;
        case (stateQ)
            storeEmpty:
            begin
                if (schedValid)
                begin
                    stateD = storeLoaded;
                end
            end
            // Stays loaded, later schedules only overwrite
            storeLoaded: stateD = storeLoaded;
            default:     stateD = storeEmpty;
        endcase
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            stateQ <= storeEmpty;
        end
        else
        begin
            stateQ <= stateD;
        end
    end

    assign keyReady = (stateQ == storeLoaded);

    // Newest schedule wins
    always_ff @(posedge clk)
    begin
        if (schedValid)
        begin
            schedQ <= schedIn;
        end
    end

    // Read port, zero outside the schedule
    always_comb
    begin
        if (rdRound <= LAST_ROUND)
        begin
            rdKey = schedQ[rdRound];
        end
        else
        begin
            rdKey = '0;
        end
    end

endmodule

//--- AesKeyScheduleTop.sv
`timescale 1ns/1ps

module AesKeyScheduleTop (
    input  logic                      clk,
    input  logic                      arstN,
    input  AESDefinitions::roundKey_t keyIn,
    input  logic                      keyValid,
    input  logic [3:0]                rdRound,
    output AESDefinitions::roundKey_t rdKey,
    output logic                      schedDone,
    output logic                      keyReady
);

    import AESDefinitions::*;

    // Full schedule from the pipeline tail
    schedule_t schedW;

    // Ten-stage expansion, one key per clock
    KeyExpansion i_expansion (
        .clk        (clk),
        .arstN      (arstN),
        .keyIn      (keyIn),
        .keyValid   (keyValid),
        .schedOut   (schedW),
        .schedValid (schedDone)
    );

    // Done strobe doubles as the store's load enable
    RoundKeyStore i_store (
        .clk        (clk),
        .arstN      (arstN),
        .schedIn    (schedW),
        .schedValid (schedDone),
        .rdRound    (rdRound),
        .rdKey      (rdKey),
        .keyReady   (keyReady)
    );

endmodule

//--- tbAesRefModel.svh
`ifndef TB_AES_REF_MODEL_SVH
`define TB_AES_REF_MODEL_SVH

// **********************************************************
// FIPS-197 key expansion, word oriented
// **********************************************************

// Rcon[i] first byte, index is i = word index / Nk
localparam logic [7:0] MODEL_RCON [1:10] = '{
    8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
    8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
};

// Words per key (Nk) and words in the whole schedule
localparam int MODEL_NK    = `AES_KEY_BYTES / `AES_WORD_BYTES;
localparam int MODEL_WORDS = MODEL_NK * `AES_SCHED_KEYS;

// Cyclic left rotation by one byte
function automatic logic [31:0] rotWord(input logic [31:0] w);
    return {w[23:0], w[31:24]};
endfunction

// S-box applied bytewise
function automatic logic [31:0] subWord(input logic [31:0] w);
    logic [31:0] res;
    for (int b = 0; b < 4; b++)
    begin
        res[8*b +: 8] = sbox(w[8*b +: 8]);
    end
    return res;
endfunction

// Whole schedule from one cipher key
function automatic schedule_t expandKey(input roundKey_t key);
    logic [127:0] flat;
    logic [31:0]  w [0:MODEL_WORDS-1];
    logic [31:0]  temp;
    schedule_t    sched;
    flat = key;
    // First Nk words are the key, first key byte on top
    for (int i = 0; i < MODEL_NK; i++)
    begin
        w[i] = flat[127-32*i -: 32];
    end
    for (int i = MODEL_NK; i < MODEL_WORDS; i++)
    begin
        temp = w[i-1];
        if (i % MODEL_NK == 0)
        begin
            temp = subWord(rotWord(temp)) ^ {MODEL_RCON[i/MODEL_NK], 24'h0};
        end
        w[i] = w[i-MODEL_NK] ^ temp;
    end
    // Four consecutive words per round key
    for (int r = 0; r < `AES_SCHED_KEYS; r++)
    begin
        sched[r] = {w[4*r], w[4*r+1], w[4*r+2], w[4*r+3]};
    end
    return sched;
endfunction

`endif

//--- tbAesKeySchedule.sv
`timescale 1ns/1ps
`include "aesKey_consts.svh"

module tbAesKeySchedule;

    import AESDefinitions::*;

    `include "tbAesRefModel.svh"

    localparam int LATENCY      = `AES_NUM_ROUNDS;
    localparam int DONE_TIMEOUT = 4 * `AES_NUM_ROUNDS;
    localparam int BURST_KEYS   = 8;

    logic       clk;
    logic       arstN;
    roundKey_t  keyIn;
    logic       keyValid;
    logic [3:0] rdRound;
    roundKey_t  rdKey;
    logic       schedDone;
    logic       keyReady;

    int seed = 32'hbfb6;

    AesKeyScheduleTop i_dut (
        .clk       (clk),
        .arstN     (arstN),
        .keyIn     (keyIn),
        .keyValid  (keyValid),
        .rdRound   (rdRound),
        .rdKey     (rdKey),
        .schedDone (schedDone),
        .keyReady  (keyReady)
    );

    // 100 ns period
    always #50 clk = ~clk;

    // **********************************************************
    // Check helpers
    // **********************************************************

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkKey(input string name, input roundKey_t exp, input roundKey_t act);
        assert (act === exp)
        else abortRun($sformatf("CHECK FAILED: %s expected %h actual %h", name, exp, act));
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        assert (act === exp)
        else abortRun($sformatf("CHECK FAILED: %s expected %h actual %h", name, exp, act));
    endtask

    task automatic checkCount(input string name, input int exp, input int act);
        assert (act == exp)
        else abortRun($sformatf("CHECK FAILED: %s expected %h actual %h", name, exp, act));
    endtask

    // **********************************************************
    // Stimulus helpers
    // **********************************************************

    task automatic makeRandomKey(output roundKey_t key);
        key = {$random(seed), $random(seed), $random(seed), $random(seed)};
    endtask

    // Returns just after the edge that samples the strobe
    task automatic sendKey(input roundKey_t key);
        @(posedge clk);
        keyIn    <= key;
        keyValid <= 1'b1;
        @(posedge clk);
        keyValid <= 1'b0;
    endtask

    // Counts edges until schedDone shows at a falling edge
    task automatic waitDone(output int edges);
        logic found;
        found = 1'b0;
        edges = 0;
        while (!found && edges < DONE_TIMEOUT)
        begin
            @(posedge clk);
            @(negedge clk);
            edges++;
            found = schedDone;
        end
        if (!found)
        begin
            abortRun($sformatf("schedDone strobe never came within %0d cycles", DONE_TIMEOUT));
        end
    endtask

    // Store read with the result valid at the next falling edge
    task automatic readRound(input logic [3:0] r);
        @(posedge clk);
        rdRound <= r;
        @(negedge clk);
    endtask

    // **********************************************************
    // Directed tests
    // **********************************************************

    task automatic testResetState();
        for (int c = 0; c < 20; c++)
        begin
            @(negedge clk);
            checkBit("schedDone after reset", 1'b0, schedDone);
            checkBit("keyReady after reset", 1'b0, keyReady);
        end
    endtask

    task automatic testKnownAnswer();
        roundKey_t key;
        schedule_t exp;
        int        edges;
        key = 128'h2b7e1516_28aed2a6_abf71588_09cf4f3c;
        exp = expandKey(key);
        sendKey(key);
        waitDone(edges);
        checkCount("schedDone latency", LATENCY, edges);
        for (int r = 0; r < `AES_SCHED_KEYS; r++)
        begin
            readRound(4'(r));
            checkKey($sformatf("rdKey round %0d", r), exp[r], rdKey);
        end
        // FIPS-197 appendix A.1 last round key
        checkKey("rdKey round 10", 128'hd014f9a8_c9ee2589_e13f0cc8_b6630ca6, rdKey);
        checkBit("keyReady", 1'b1, keyReady);
        checkBit("schedDone", 1'b0, schedDone);
    endtask

    task automatic testOutOfRange();
        for (int r = `AES_SCHED_KEYS; r < 16; r++)
        begin
            readRound(4'(r));
            checkKey($sformatf("rdKey round %0d", r), '0, rdKey);
        end
    endtask

    task automatic testBackToBack();
        roundKey_t  keys [0:BURST_KEYS-1];
        logic [3:0] rounds [0:BURST_KEYS-1];
        schedule_t  exp;
        int         edges;
        for (int i = 0; i < BURST_KEYS; i++)
        begin
            makeRandomKey(keys[i]);
            rounds[i] = 4'({$random(seed)} % `AES_SCHED_KEYS);
        end
        for (int i = 0; i < BURST_KEYS; i++)
        begin
            @(posedge clk);
            keyIn    <= keys[i];
            keyValid <= 1'b1;
        end
        @(posedge clk);
        keyValid <= 1'b0;
        // Already BURST_KEYS-1 edges past the first strobe
        waitDone(edges);
        checkCount("first schedDone latency", LATENCY, edges + BURST_KEYS - 1);
        for (int i = 0; i < BURST_KEYS; i++)
        begin
            checkBit($sformatf("schedDone pulse %0d", i), 1'b1, schedDone);
            exp = expandKey(keys[i]);
            readRound(rounds[i]);
            checkKey($sformatf("rdKey key %0d round %0d", i, rounds[i]), exp[rounds[i]],
                rdKey);
        end
        checkBit("schedDone after burst", 1'b0, schedDone);
    endtask

    task automatic testOverwriteHold();
        roundKey_t key;
        schedule_t exp;
        int        edges;
        makeRandomKey(key);
        exp = expandKey(key);
        sendKey(key);
        waitDone(edges);
        checkCount("schedDone latency", LATENCY, edges);
        // Walk all rounds repeatedly while idle
        for (int c = 0; c < 30; c++)
        begin
            readRound(4'(c % `AES_SCHED_KEYS));
            checkKey($sformatf("held rdKey round %0d", c % `AES_SCHED_KEYS),
                exp[c % `AES_SCHED_KEYS], rdKey);
            checkBit("keyReady while idle", 1'b1, keyReady);
            checkBit("schedDone while idle", 1'b0, schedDone);
        end
    endtask

    // **********************************************************
    // Main sequence
    // **********************************************************

    initial
    begin
        clk      = 1'b0;
        arstN    = 1'b0;
        keyIn    = '0;
        keyValid = 1'b0;
        rdRound  = '0;
        repeat (16) @(posedge clk);
        arstN <= 1'b1;
        testResetState();
        testKnownAnswer();
        testOutOfRange();
        testBackToBack();
        testOverwriteHold();
        $display("TB PASSED");
        $finish;
    end

endmodule

//--- aesKeySchedule.f
+incdir+.
AESDefinitions.sv
KeyRound.sv
KeyExpansion.sv
RoundKeyStore.sv
AesKeyScheduleTop.sv
tbAesKeySchedule.sv

//--- run.sh
#!/bin/sh
# Build and run the AES key schedule testbench with Verilator
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tbAesKeySchedule -f aesKeySchedule.f > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/VtbAesKeySchedule > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The log decides the verdict
if grep -q "^TB PASSED$" "$SIM_LOG"; then
    echo "Simulation passed"
    exit 0
fi
echo "Pass message missing from $SIM_LOG"
exit 1
